// ==== compile.f ====
common/mem_bridge_pkg.sv
hdl/sync_fifo.sv
front/req_capture.sv
issue/app_cmd_issue.sv
hdl/mem_bridge_top.sv
test/mem_bridge_props.sv
test/app_mem_model.sv
test/tb_mem_bridge.sv

// ==== Makefile ====
# Verilator flow for the memory bridge testbench
# override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_mem_bridge
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
FAIL_MSG  ?= Checks failed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== test/tb_mem_bridge.sv ====
// memory bridge testbench: clock, reset, core stimulus and timeout
// shadow-word reference, line and flag compare, per-test report
`timescale 1ns/10ps
`default_nettype none

module tb_mem_bridge;

    localparam int N_RAND  = 8;
    localparam int N_MERGE = 6;
    localparam int N_BURST = 12;
    // calibration step, then the writes and reads of each test
    localparam int N_OPS      = 1 + 2 * N_RAND + 3 * N_MERGE + 2 * N_BURST + 5;
    localparam int MAX_CYCLES = 300 * N_OPS;

    logic                       clk;
    logic                       rst_x_async;
    logic                       i_calib_done;
    logic                       i_wr_en;
    logic                       i_rd_en;
    mem_bridge_pkg::core_addr_t i_addr;
    mem_bridge_pkg::core_word_t i_wdata;
    mem_bridge_pkg::core_mask_t i_mask;
    mem_bridge_pkg::line_t      o_rd_data;
    logic                       o_busy;
    logic                       app_rdy;
    logic                       app_wdf_rdy;
    mem_bridge_pkg::line_t      app_rd_data;
    logic                       app_rd_valid;
    logic                       app_en;
    mem_bridge_pkg::app_cmd_t   app_cmd;
    mem_bridge_pkg::app_addr_t  app_addr;
    logic                       app_wdf_wren;
    mem_bridge_pkg::line_t      app_wdf_data;
    mem_bridge_pkg::line_mask_t app_wdf_mask;

    logic [31:0]                lfsr;
    mem_bridge_pkg::core_word_t shadow [256];
    mem_bridge_pkg::core_addr_t addr_list [N_BURST];
    mem_bridge_pkg::line_t      exp_q [$];
    int                         errors;
    int                         checks;
    int                         tests_done;
    int                         cycles;

    mem_bridge_top dut (
        .clk (clk), .rst_x_async (rst_x_async),
        .i_wr_en (i_wr_en), .i_rd_en (i_rd_en), .i_addr (i_addr),
        .i_wdata (i_wdata), .i_mask (i_mask), .o_rd_data (o_rd_data), .o_busy (o_busy),
        .i_calib_done (i_calib_done), .i_app_rdy (app_rdy), .i_app_wdf_rdy (app_wdf_rdy),
        .i_app_rd_data (app_rd_data), .i_app_rd_data_valid (app_rd_valid),
        .o_app_en (app_en), .o_app_cmd (app_cmd), .o_app_addr (app_addr),
        .o_app_wdf_wren (app_wdf_wren), .o_app_wdf_data (app_wdf_data),
        .o_app_wdf_mask (app_wdf_mask)
    );

    app_mem_model u_mem (
        .clk (clk), .i_app_en (app_en), .i_app_cmd (app_cmd), .i_app_addr (app_addr),
        .i_app_wdf_wren (app_wdf_wren), .i_app_wdf_data (app_wdf_data),
        .i_app_wdf_mask (app_wdf_mask), .o_app_rdy (app_rdy), .o_app_wdf_rdy (app_wdf_rdy),
        .o_app_rd_data (app_rd_data), .o_app_rd_data_valid (app_rd_valid)
    );

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int k = 0; k < n; k++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic mem_bridge_pkg::core_mask_t rand_mask();
        logic [31:0] r;
        r = rand_bits(mem_bridge_pkg::CORE_MASK_W);
        return r[mem_bridge_pkg::CORE_MASK_W-1:0];
    endfunction

    // expected line: the four shadow words of the addressed line, lane 0 lowest
    function automatic mem_bridge_pkg::line_t ref_line(input mem_bridge_pkg::core_addr_t addr);
        mem_bridge_pkg::line_t l;
        for (int w = 0; w < mem_bridge_pkg::WORDS_PER_LINE; w++) begin
            l[32*w +: 32] = shadow[{addr[9:4], 2'(w)}];
        end
        return l;
    endfunction

    // a set mask bit keeps the old byte
    task automatic record_write(input mem_bridge_pkg::core_addr_t addr,
                                input mem_bridge_pkg::core_word_t data,
                                input mem_bridge_pkg::core_mask_t mask);
        for (int b = 0; b < mem_bridge_pkg::CORE_MASK_W; b++) begin
            if (!mask[b]) begin
                shadow[addr[9:2]][8*b +: 8] = data[8*b +: 8];
            end
        end
    endtask

    task automatic check_line(input string name, input mem_bridge_pkg::line_t got,
                              input mem_bridge_pkg::line_t exp);
        checks++;
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic wait_idle();
        while (o_busy) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic core_write(input mem_bridge_pkg::core_addr_t addr,
                              input mem_bridge_pkg::core_word_t data,
                              input mem_bridge_pkg::core_mask_t mask);
        wait_idle();
        i_wr_en = 1'b1;
        i_addr  = addr;
        i_wdata = data;
        i_mask  = mask;
        @(posedge clk);
        #1;
        i_wr_en = 1'b0;
        record_write(addr, data, mask);
    endtask

    task automatic core_read(input mem_bridge_pkg::core_addr_t addr);
        wait_idle();
        i_rd_en = 1'b1;
        i_addr  = addr;
        @(posedge clk);
        #1;
        i_rd_en = 1'b0;
        exp_q.push_back(ref_line(addr));
    endtask

    task automatic drain();
        while (exp_q.size() != 0 || o_busy) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic report_test(input string name, input int base);
        tests_done++;
        if (errors == base) begin
            $display("test %0d %s: ok", tests_done, name);
        end else begin
            $display("test %0d %s: %0d errors", tests_done, name, errors - base);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // the read in flight ends where o_busy has fallen
    always @(posedge clk) begin
        if (!o_busy && exp_q.size() != 0) begin
            check_line("o_rd_data", o_rd_data, exp_q.pop_front());
        end
    end

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run stopped after %0d cycles", cycles);
        $display("Checks failed");
        $finish;
    end

    initial begin
        mem_bridge_pkg::core_addr_t addr;
        int                         base;
        int                         n;
        lfsr         = 32'haedb3ec4;
        errors       = 0;
        checks       = 0;
        tests_done   = 0;
        rst_x_async  = 1'b0;
        i_calib_done = 1'b0;
        i_wr_en      = 1'b0;
        i_rd_en      = 1'b0;
        i_addr       = '0;
        i_wdata      = '0;
        i_mask       = '0;
        for (int i = 0; i < 256; i++) begin
            shadow[i] = '0;
        end
        repeat (16) @(posedge clk);
        #1;
        rst_x_async = 1'b1;

        // busy until the synchronized calibration flag arrives
        base = errors;
        repeat (8) begin
            @(posedge clk);
            #1;
            check_flag("o_busy", o_busy, 1'b1);
            check_flag("o_app_en", app_en, 1'b0);
            check_flag("o_app_wdf_wren", app_wdf_wren, 1'b0);
        end
        i_calib_done = 1'b1;
        n = 0;
        while (o_busy && n < 10) begin
            @(posedge clk);
            #1;
            n++;
        end
        checks++;
        if (n < 2 || n > 3) begin
            $display("o_busy fell %0d cycles after calibration done, expected 2 or 3", n);
            errors++;
        end
        report_test("calibration wait", base);

        base = errors;
        for (int i = 0; i < N_RAND; i++) begin
            addr_list[i] = rand_bits(32);
            core_write(addr_list[i], rand_bits(32), '0);
        end
        for (int i = 0; i < N_RAND; i++) begin
            core_read(addr_list[i]);
        end
        drain();
        report_test("full-mask writes", base);

        base = errors;
        for (int i = 0; i < N_MERGE; i++) begin
            addr = rand_bits(32);
            core_write(addr, rand_bits(32), '0);
            core_write(addr, rand_bits(32), rand_mask());
            core_read(addr);
        end
        drain();
        report_test("partial-mask merge", base);

        // four lines only, so later writes hit earlier words
        base = errors;
        for (int i = 0; i < N_BURST; i++) begin
            addr_list[i] = rand_bits(32) & 32'hffff_fc3f;
            core_write(addr_list[i], rand_bits(32), rand_mask());
        end
        for (int i = 0; i < N_BURST; i++) begin
            core_read(addr_list[i]);
        end
        drain();
        report_test("write burst under stalls", base);

        base = errors;
        addr = rand_bits(32) & 32'hffff_fff3;
        for (int w = 0; w < mem_bridge_pkg::WORDS_PER_LINE; w++) begin
            core_write(addr + 32'(4 * w), rand_bits(32), '0);
        end
        core_read(addr);
        drain();
        report_test("whole line", base);

        $display("tests: %0d  checks: %0d  errors: %0d", tests_done, checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/app_mem_model.sv ====
// behavioral model of the dram application port
// 64-line memory with byte-masked writes, lfsr ready stalls, read latency
`timescale 1ns/10ps
`default_nettype none

module app_mem_model #(
    parameter logic [31:0] SEED = 32'haedb3ec4
) (
    input  wire                             clk,
    input  wire                             i_app_en,
    input  wire mem_bridge_pkg::app_cmd_t   i_app_cmd,
    input  wire mem_bridge_pkg::app_addr_t  i_app_addr,
    input  wire                             i_app_wdf_wren,
    input  wire mem_bridge_pkg::line_t      i_app_wdf_data,
    input  wire mem_bridge_pkg::line_mask_t i_app_wdf_mask,
    output logic                            o_app_rdy,
    output logic                            o_app_wdf_rdy,
    output mem_bridge_pkg::line_t           o_app_rd_data,
    output logic                            o_app_rd_data_valid
);

    mem_bridge_pkg::line_t      mem [64];
    logic [31:0]                lfsr;
    logic                       have_cmd;
    logic                       have_data;
    mem_bridge_pkg::app_addr_t  wr_addr;
    mem_bridge_pkg::line_t      wr_line;
    mem_bridge_pkg::line_mask_t wr_mask;
    mem_bridge_pkg::app_addr_t  rd_addr;
    int                         rd_wait;
    logic                       rd_fire;

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int k = 0; k < n; k++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    initial begin
        lfsr                = SEED;
        have_cmd            = 1'b0;
        have_data           = 1'b0;
        rd_wait             = 0;
        o_app_rdy           = 1'b0;
        o_app_wdf_rdy       = 1'b0;
        o_app_rd_data       = '0;
        o_app_rd_data_valid = 1'b0;
        for (int i = 0; i < 64; i++) begin
            mem[i] = '0;
        end
    end

    always @(posedge clk) begin
        // read in flight fires when its countdown runs out
        rd_fire = (rd_wait == 1);
        if (rd_wait > 0) begin
            rd_wait--;
        end
        if (i_app_en && o_app_rdy) begin
            if (i_app_cmd == mem_bridge_pkg::APP_CMD_READ) begin
                rd_addr = i_app_addr;
                rd_wait = 2 + int'(rand_bits(2));
            end else begin
                have_cmd = 1'b1;
                wr_addr  = i_app_addr;
            end
        end
        if (i_app_wdf_wren && o_app_wdf_rdy) begin
            have_data = 1'b1;
            wr_line   = i_app_wdf_data;
            wr_mask   = i_app_wdf_mask;
        end
        // a write lands once command and data are both in
        if (have_cmd && have_data) begin
            for (int b = 0; b < mem_bridge_pkg::LINE_MASK_W; b++) begin
                if (!wr_mask[b]) begin
                    mem[wr_addr[8:3]][8*b +: 8] = wr_line[8*b +: 8];
                end
            end
            have_cmd  = 1'b0;
            have_data = 1'b0;
        end
        #1;
        o_app_rdy           = (rand_bits(2) != 0);
        o_app_wdf_rdy       = (rand_bits(2) != 0);
        o_app_rd_data_valid = rd_fire;
        if (rd_fire) begin
            o_app_rd_data = mem[rd_addr[8:3]];
        end
    end

endmodule

`default_nettype wire

// ==== test/mem_bridge_props.sv ====
// application-port handshake assertions, bound into the bridge top
// hold-until-accepted, read fifo overflow, no command before a request
`timescale 1ns/10ps
`default_nettype none

module mem_bridge_props (
    input wire                             clk,
    input wire                             rst_x_async,
    input wire                             i_app_en,
    input wire mem_bridge_pkg::app_cmd_t   i_app_cmd,
    input wire mem_bridge_pkg::app_addr_t  i_app_addr,
    input wire                             i_app_rdy,
    input wire                             i_app_wdf_wren,
    input wire mem_bridge_pkg::line_t      i_app_wdf_data,
    input wire mem_bridge_pkg::line_mask_t i_app_wdf_mask,
    input wire                             i_app_wdf_rdy,
    input wire                             i_rd_push,
    input wire                             i_rd_full,
    input wire                             i_req_empty
);

    logic req_seen;

    // set once the request fifo has held anything
    always_ff @(posedge clk or negedge rst_x_async) begin
        if (!rst_x_async) begin
            req_seen <= 1'b0;
        end else if (!i_req_empty) begin
            req_seen <= 1'b1;
        end
    end

    a_cmd_held: assert property (@(posedge clk) disable iff (!rst_x_async)
        i_app_en && !i_app_rdy |=> i_app_en && $stable(i_app_cmd) && $stable(i_app_addr))
        else $error("application command changed before it was accepted");

    a_wdata_held: assert property (@(posedge clk) disable iff (!rst_x_async)
        i_app_wdf_wren && !i_app_wdf_rdy |=>
            i_app_wdf_wren && $stable(i_app_wdf_data) && $stable(i_app_wdf_mask))
        else $error("write data changed before it was accepted");

    a_rd_no_overflow: assert property (@(posedge clk) disable iff (!rst_x_async)
        !(i_rd_push && i_rd_full))
        else $error("read fifo pushed while full");

    a_no_early_cmd: assert property (@(posedge clk) disable iff (!rst_x_async)
        !req_seen |-> !i_app_en)
        else $error("command issued with no request queued since reset");

endmodule

bind mem_bridge_top mem_bridge_props u_props (
    .clk            (clk),
    .rst_x_async    (rst_x_async),
    .i_app_en       (o_app_en),
    .i_app_cmd      (o_app_cmd),
    .i_app_addr     (o_app_addr),
    .i_app_rdy      (i_app_rdy),
    .i_app_wdf_wren (o_app_wdf_wren),
    .i_app_wdf_data (o_app_wdf_data),
    .i_app_wdf_mask (o_app_wdf_mask),
    .i_app_wdf_rdy  (i_app_wdf_rdy),
    .i_rd_push      (i_app_rd_data_valid),
    .i_rd_full      (rd_fifo_full),
    .i_req_empty    (req_empty)
);

`default_nettype wire

// ==== hdl/mem_bridge_top.sv ====
// bridge top: core port to dram application port
// capture stage, request fifo, command issue, read-return fifo
`timescale 1ns/10ps
`default_nettype none

module mem_bridge_top (
    input  wire                                clk,
    input  wire                                rst_x_async,
    // core port
    input  wire                                i_wr_en,
    input  wire                                i_rd_en,
    input  wire mem_bridge_pkg::core_addr_t    i_addr,
    input  wire mem_bridge_pkg::core_word_t    i_wdata,
    input  wire mem_bridge_pkg::core_mask_t    i_mask,
    output mem_bridge_pkg::line_t              o_rd_data,
    output logic                               o_busy,
    // application port
    input  wire                                i_calib_done,
    input  wire                                i_app_rdy,
    input  wire                                i_app_wdf_rdy,
    input  wire mem_bridge_pkg::line_t         i_app_rd_data,
    input  wire                                i_app_rd_data_valid,
    output logic                               o_app_en,
    output mem_bridge_pkg::app_cmd_t           o_app_cmd,
    output mem_bridge_pkg::app_addr_t          o_app_addr,
    output logic                               o_app_wdf_wren,
    output mem_bridge_pkg::line_t              o_app_wdf_data,
    output mem_bridge_pkg::line_mask_t         o_app_wdf_mask
);

    // capture -> request fifo -> issue
    logic                  req_push;
    mem_bridge_pkg::req_t  req_in;
    logic                  req_pop;
    mem_bridge_pkg::req_t  req_head;
    logic                  req_empty;
    logic                  req_full;

    // read data back to capture
    logic                  rd_pop;
    mem_bridge_pkg::line_t rd_line;
    logic                  rd_empty;
    logic                  rd_fifo_full;

    req_capture u_capture (
        .clk          (clk),
        .rst_x_async  (rst_x_async),
        .i_calib_done (i_calib_done),
        .i_wr_en      (i_wr_en),
        .i_rd_en      (i_rd_en),
        .i_addr       (i_addr),
        .i_wdata      (i_wdata),
        .i_mask       (i_mask),
        .i_req_full   (req_full),
        .i_rd_empty   (rd_empty),
        .i_rd_line    (rd_line),
        .o_req_push   (req_push),
        .o_req        (req_in),
        .o_rd_pop     (rd_pop),
        .o_rd_data    (o_rd_data),
        .o_busy       (o_busy)
    );

    sync_fifo #(
        .payload_t (mem_bridge_pkg::req_t),
        .DEPTH     (mem_bridge_pkg::FIFO_DEPTH)
    ) u_req_fifo (
        .clk         (clk),
        .rst_x_async (rst_x_async),
        .i_push      (req_push),
        .i_push_data (req_in),
        .i_pop       (req_pop),
        .o_pop_data  (req_head),
        .o_empty     (req_empty),
        .o_full      (req_full)
    );

    app_cmd_issue u_issue (
        .clk            (clk),
        .rst_x_async    (rst_x_async),
        .i_req_empty    (req_empty),
        .i_req          (req_head),
        .i_app_rdy      (i_app_rdy),
        .i_app_wdf_rdy  (i_app_wdf_rdy),
        .o_req_pop      (req_pop),
        .o_app_en       (o_app_en),
        .o_app_cmd      (o_app_cmd),
        .o_app_addr     (o_app_addr),
        .o_app_wdf_wren (o_app_wdf_wren),
        .o_app_wdf_data (o_app_wdf_data),
        .o_app_wdf_mask (o_app_wdf_mask)
    );

    // no back-pressure toward the controller, one read in flight at most
    sync_fifo #(
        .payload_t (mem_bridge_pkg::line_t),
        .DEPTH     (mem_bridge_pkg::FIFO_DEPTH)
    ) u_rd_fifo (
        .clk         (clk),
        .rst_x_async (rst_x_async),
        .i_push      (i_app_rd_data_valid),
        .i_push_data (i_app_rd_data),
        .i_pop       (rd_pop),
        .o_pop_data  (rd_line),
        .o_empty     (rd_empty),
        .o_full      (rd_fifo_full)
    );

endmodule

`default_nettype wire

// ==== issue/app_cmd_issue.sv ====
// application port issue: command and write data with separate readiness
// idle/cmd_wdata/cmd/wdata fsm, chains into the next queued request
// lane mapping of the core word into the 128-bit line
`timescale 1ns/10ps
`default_nettype none

module app_cmd_issue (
    input  wire                             clk,
    input  wire                             rst_x_async,
    input  wire                             i_req_empty,
    input  wire mem_bridge_pkg::req_t       i_req,
    input  wire                             i_app_rdy,
    input  wire                             i_app_wdf_rdy,
    output logic                            o_req_pop,
    output logic                            o_app_en,
    output mem_bridge_pkg::app_cmd_t        o_app_cmd,
    output mem_bridge_pkg::app_addr_t       o_app_addr,
    output logic                            o_app_wdf_wren,
    output mem_bridge_pkg::line_t           o_app_wdf_data,
    output mem_bridge_pkg::line_mask_t      o_app_wdf_mask
);

    mem_bridge_pkg::issue_state_t state;
    logic                         can_take;
    logic [1:0]                   lane;
    mem_bridge_pkg::app_addr_t    line_addr;
    mem_bridge_pkg::line_t        line_data;
    mem_bridge_pkg::line_mask_t   line_mask;

    // free now, or every outstanding handshake completes this cycle
    always_comb begin
        case (state)
            mem_bridge_pkg::ISSUE_IDLE:      can_take = 1'b1;
            mem_bridge_pkg::ISSUE_CMD_WDATA: can_take = i_app_rdy && i_app_wdf_rdy;
            mem_bridge_pkg::ISSUE_CMD:       can_take = i_app_rdy;
            mem_bridge_pkg::ISSUE_WDATA:     can_take = i_app_wdf_rdy;
            default:                         can_take = 1'b0;
        endcase
    end

    assign o_req_pop = can_take && !i_req_empty;

    // lane mapping
    assign lane      = i_req.addr[3:2];
    assign line_addr = {2'b00, i_req.addr[26:4], 3'b000};
    assign line_data = {mem_bridge_pkg::WORDS_PER_LINE{i_req.data}};

    always_comb begin
        // unselected lanes stay masked off
        line_mask = '1;
        line_mask[lane*mem_bridge_pkg::CORE_MASK_W +: mem_bridge_pkg::CORE_MASK_W] = i_req.mask;
    end

    always_ff @(posedge clk or negedge rst_x_async) begin
        if (!rst_x_async) begin
            state          <= mem_bridge_pkg::ISSUE_IDLE;
            o_app_en       <= 1'b0;
            o_app_wdf_wren <= 1'b0;
        end else if (o_req_pop) begin
            o_app_en       <= 1'b1;
            o_app_wdf_wren <= i_req.wr;
            state          <= i_req.wr ? mem_bridge_pkg::ISSUE_CMD_WDATA
                                       : mem_bridge_pkg::ISSUE_CMD;
        end else begin
            case (state)
                mem_bridge_pkg::ISSUE_CMD_WDATA: begin
                    if (i_app_rdy && i_app_wdf_rdy) begin
                        o_app_en       <= 1'b0;
                        o_app_wdf_wren <= 1'b0;
                        state          <= mem_bridge_pkg::ISSUE_IDLE;
                    end else if (i_app_rdy) begin
                        // command taken, data still waiting
                        o_app_en <= 1'b0;
                        state    <= mem_bridge_pkg::ISSUE_WDATA;
                    end else if (i_app_wdf_rdy) begin
                        o_app_wdf_wren <= 1'b0;
                        state          <= mem_bridge_pkg::ISSUE_CMD;
                    end
                end
                mem_bridge_pkg::ISSUE_CMD: begin
                    if (i_app_rdy) begin
                        o_app_en <= 1'b0;
                        state    <= mem_bridge_pkg::ISSUE_IDLE;
                    end
                end
                mem_bridge_pkg::ISSUE_WDATA: begin
                    if (i_app_wdf_rdy) begin
                        o_app_wdf_wren <= 1'b0;
                        state          <= mem_bridge_pkg::ISSUE_IDLE;
                    end
                end
                default: begin
                    o_app_en       <= 1'b0;
                    o_app_wdf_wren <= 1'b0;
                    state          <= mem_bridge_pkg::ISSUE_IDLE;
                end
            endcase
        end
    end

    // command payload, loaded with the pop
    always_ff @(posedge clk) begin
        if (o_req_pop) begin
            o_app_cmd      <= i_req.wr ? mem_bridge_pkg::APP_CMD_WRITE
                                       : mem_bridge_pkg::APP_CMD_READ;
            o_app_addr     <= line_addr;
            o_app_wdf_data <= line_data;
            o_app_wdf_mask <= line_mask;
        end
    end

endmodule

`default_nettype wire

// ==== front/req_capture.sv ====
// core request capture: calibration synchronizer and busy flag
// calib/idle/write/read fsm, request record build, read line return
`timescale 1ns/10ps
`default_nettype none

module req_capture (
    input  wire                             clk,
    input  wire                             rst_x_async,
    input  wire                             i_calib_done,
    input  wire                             i_wr_en,
    input  wire                             i_rd_en,
    input  wire mem_bridge_pkg::core_addr_t i_addr,
    input  wire mem_bridge_pkg::core_word_t i_wdata,
    input  wire mem_bridge_pkg::core_mask_t i_mask,
    input  wire                             i_req_full,
    input  wire                             i_rd_empty,
    input  wire mem_bridge_pkg::line_t      i_rd_line,
    output logic                            o_req_push,
    output mem_bridge_pkg::req_t            o_req,
    output logic                            o_rd_pop,
    output mem_bridge_pkg::line_t           o_rd_data,
    output logic                            o_busy
);

    mem_bridge_pkg::front_state_t state;
    logic                         calib_sync1;
    logic                         calib_sync2;
    logic                         accept;

    // two-flop synchronizer for the calibration flag
    always_ff @(posedge clk or negedge rst_x_async) begin
        if (!rst_x_async) begin
            calib_sync1 <= 1'b0;
            calib_sync2 <= 1'b0;
        end else begin
            calib_sync1 <= i_calib_done;
            calib_sync2 <= calib_sync1;
        end
    end

    assign accept   = (state == mem_bridge_pkg::FRONT_IDLE) && (i_wr_en || i_rd_en);
    assign o_rd_pop = (state == mem_bridge_pkg::FRONT_READ) && !i_rd_empty;
    assign o_busy   = (state != mem_bridge_pkg::FRONT_IDLE);

    always_ff @(posedge clk or negedge rst_x_async) begin
        if (!rst_x_async) begin
            state      <= mem_bridge_pkg::FRONT_CALIB;
            o_req_push <= 1'b0;
        end else begin
            case (state)
                mem_bridge_pkg::FRONT_CALIB: begin
                    if (calib_sync2) begin
                        state <= mem_bridge_pkg::FRONT_IDLE;
                    end
                end
                mem_bridge_pkg::FRONT_IDLE: begin
                    if (i_wr_en) begin
                        state      <= mem_bridge_pkg::FRONT_WRITE;
                        o_req_push <= 1'b1;
                    end else if (i_rd_en) begin
                        state      <= mem_bridge_pkg::FRONT_READ;
                        o_req_push <= 1'b1;
                    end
                end
                mem_bridge_pkg::FRONT_WRITE: begin
                    // push lands on this edge once there is room
                    if (!i_req_full) begin
                        state      <= mem_bridge_pkg::FRONT_IDLE;
                        o_req_push <= 1'b0;
                    end
                end
                mem_bridge_pkg::FRONT_READ: begin
                    if (!i_req_full) begin
                        o_req_push <= 1'b0;
                    end
                    if (!i_rd_empty) begin
                        state <= mem_bridge_pkg::FRONT_IDLE;
                    end
                end
                default: begin
                    state      <= mem_bridge_pkg::FRONT_CALIB;
                    o_req_push <= 1'b0;
                end
            endcase
        end
    end

    // request record and returned line
    always_ff @(posedge clk) begin
        if (accept) begin
            o_req.wr   <= i_wr_en;
            o_req.addr <= i_addr;
            o_req.data <= i_wdata;
            o_req.mask <= i_wr_en ? i_mask : '0;
        end
        if (o_rd_pop) begin
            o_rd_data <= i_rd_line;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/sync_fifo.sv ====
// synchronous fifo with a type-parameterized payload
// head entry is visible on the pop side (first-word fall-through)
`timescale 1ns/10ps
`default_nettype none

module sync_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  wire           clk,
    input  wire           rst_x_async,
    input  wire           i_push,
    input  wire payload_t i_push_data,
    input  wire           i_pop,
    output payload_t      o_pop_data,
    output logic          o_empty,
    output logic          o_full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t           mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               do_push;
    logic               do_pop;

    assign do_push = i_push && !o_full;
    assign do_pop  = i_pop && !o_empty;

    assign o_empty    = (count == '0);
    assign o_full     = (count == CNT_W'(DEPTH));
    assign o_pop_data = mem[rd_ptr];

    always_ff @(posedge clk or negedge rst_x_async) begin
        if (!rst_x_async) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // occupancy only moves when exactly one side acts
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= i_push_data;
        end
    end

endmodule

`default_nettype wire

// ==== common/mem_bridge_pkg.sv ====
// shared widths and depths for the memory bridge
// core and line payload types, the request record
// application command codes, capture and issue state encodings
`default_nettype none

package mem_bridge_pkg;

    // core side
    localparam int CORE_ADDR_W = 32;
    localparam int CORE_DATA_W = 32;
    localparam int CORE_MASK_W = 4;

    // application side
    localparam int LINE_W         = 128;
    localparam int LINE_MASK_W    = 16;
    localparam int APP_ADDR_W     = 28;
    localparam int WORDS_PER_LINE = 4;

    // entries per fifo
    localparam int FIFO_DEPTH = 4;

    typedef logic [CORE_ADDR_W-1:0] core_addr_t;
    typedef logic [CORE_DATA_W-1:0] core_word_t;
    typedef logic [CORE_MASK_W-1:0] core_mask_t;

    typedef logic [LINE_W-1:0]      line_t;
    typedef logic [LINE_MASK_W-1:0] line_mask_t;
    typedef logic [APP_ADDR_W-1:0]  app_addr_t;

    typedef enum logic [2:0] {
        APP_CMD_WRITE = 3'd0,
        APP_CMD_READ  = 3'd1
    } app_cmd_t;

    // one queued core request, mask is zero for reads
    typedef struct packed {
        logic       wr;
        core_addr_t addr;
        core_word_t data;
        core_mask_t mask;
    } req_t;

    typedef enum logic [1:0] {
        FRONT_CALIB = 2'd0,
        FRONT_IDLE  = 2'd1,
        FRONT_WRITE = 2'd2,
        FRONT_READ  = 2'd3
    } front_state_t;

    typedef enum logic [1:0] {
        ISSUE_IDLE      = 2'd0,
        ISSUE_CMD_WDATA = 2'd1,
        ISSUE_CMD       = 2'd2,
        ISSUE_WDATA     = 2'd3
    } issue_state_t;

endpackage

`default_nettype wire
